/* cache_top.f */
+incdir+common
common/cache_pkg.sv
hw/dual_port_lutram.sv
cache/cache_ctrl_fsm.sv
cache/cache_stat_counters.sv
hw/cache_top.sv
bench/cache_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= cache_top_tb
FILELIST  ?= cache_top.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* bench/cache_top_tb.sv */
`default_nettype none
`include "cache_defs.svh"

module cache_top_tb;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_TESTS       = 17;
    localparam int RESP_LIMIT      = 20; // cycles one request may take.
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 20 + 8;
    localparam int MODEL_WORDS     = 256;

    typedef struct packed
    {
        logic                           do_reset;
        cache_pkg::cache_op_e           op;
        logic [`ADDR_WIDTH - 1 : 0]     addr;
        logic [`WORD_WIDTH - 1 : 0]     wdata;
        logic [`BYTE_LANES - 1 : 0]     mask;
        logic                           exp_hit;
    } stim_t;

    logic                               clk_in = 1'b0;
    logic                               reset_in;
    cache_pkg::cache_req_t              req;
    logic                               req_valid;
    logic                               ready;
    cache_pkg::cache_resp_t             resp;
    logic                               resp_valid;
    logic                               fill_req;
    logic [`ADDR_WIDTH - 1 : 0]         fill_addr;
    logic                               fill_valid = 1'b0;
    logic [`WORD_WIDTH - 1 : 0]         fill_data = '0;
    logic                               mem_wr;
    logic [`ADDR_WIDTH - 1 : 0]         mem_addr;
    logic [`WORD_WIDTH - 1 : 0]         mem_wdata;
    logic [`BYTE_LANES - 1 : 0]         mem_mask;
    logic [15:0]                        hit_count;
    logic [15:0]                        miss_count;

    logic [`WORD_WIDTH - 1 : 0]         model_mem [MODEL_WORDS];
    logic                               ref_valid [`NUM_SET];
    logic [`TAG_WIDTH - 1 : 0]          ref_tag [`NUM_SET];
    stim_t                              tests [NUM_TESTS];
    logic [15:0]                        lfsr_state;
    int                                 fill_delay = 1;
    int                                 error_count;
    int                                 exp_hits;
    int                                 exp_misses;

    logic                               fill_pending = 1'b0;
    int                                 fill_wait = 0;
    logic [`ADDR_WIDTH - 1 : 0]         fill_addr_q = '0;

    cache_top dut0
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .req        (req),
        .req_valid  (req_valid),
        .ready      (ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .fill_req   (fill_req),
        .fill_addr  (fill_addr),
        .fill_valid (fill_valid),
        .fill_data  (fill_data),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_mask   (mem_mask),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] value);
        logic feedback;
        feedback = value[15] ^ value[13] ^ value[12] ^ value[10];
        return {value[14:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch at time %0t: %s expected 0x%h, got 0x%h",
                 $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string text);
        $display("error at time %0t: %s", $time, text);
        error_count++;
    endtask

    task automatic load_tests();
        tests[0]  = '{1'b0, cache_pkg::op_read,  8'h13, 32'h0000_0000, 4'b0000, 1'b0};
        tests[1]  = '{1'b0, cache_pkg::op_read,  8'h13, 32'h0000_0000, 4'b0000, 1'b1};
        tests[2]  = '{1'b0, cache_pkg::op_write, 8'h13, 32'ha5a5_5a5a, 4'b0101, 1'b1};
        tests[3]  = '{1'b0, cache_pkg::op_read,  8'h13, 32'h0000_0000, 4'b0000, 1'b1};
        tests[4]  = '{1'b0, cache_pkg::op_write, 8'h27, 32'hdead_beef, 4'b1100, 1'b0};
        tests[5]  = '{1'b0, cache_pkg::op_read,  8'h27, 32'h0000_0000, 4'b0000, 1'b0};
        tests[6]  = '{1'b0, cache_pkg::op_read,  8'h27, 32'h0000_0000, 4'b0000, 1'b1};
        tests[7]  = '{1'b0, cache_pkg::op_read,  8'h53, 32'h0000_0000, 4'b0000, 1'b0};
        tests[8]  = '{1'b0, cache_pkg::op_read,  8'h13, 32'h0000_0000, 4'b0000, 1'b0};
        tests[9]  = '{1'b0, cache_pkg::op_read,  8'h53, 32'h0000_0000, 4'b0000, 1'b0};
        tests[10] = '{1'b1, cache_pkg::op_read,  8'h00, 32'h0000_0000, 4'b0000, 1'b0};
        tests[11] = '{1'b0, cache_pkg::op_read,  8'h13, 32'h0000_0000, 4'b0000, 1'b0};
        tests[12] = '{1'b0, cache_pkg::op_read,  8'h13, 32'h0000_0000, 4'b0000, 1'b1};
        tests[13] = '{1'b0, cache_pkg::op_write, 8'hf0, 32'h1234_5678, 4'b1111, 1'b0};
        tests[14] = '{1'b0, cache_pkg::op_read,  8'hf0, 32'h0000_0000, 4'b0000, 1'b0};
        tests[15] = '{1'b0, cache_pkg::op_write, 8'hf0, 32'h00c3_0000, 4'b0010, 1'b1};
        tests[16] = '{1'b0, cache_pkg::op_read,  8'hf0, 32'h0000_0000, 4'b0000, 1'b1};
    endtask

    task automatic apply_reset();
        reset_in <= 1'b1;
        repeat (4) @(posedge clk_in);
        reset_in <= 1'b0;
        for (int s = 0; s < `NUM_SET; s++)
        begin
            ref_valid[s] = 1'b0;
        end
        exp_hits   = 0;
        exp_misses = 0;
    endtask

    task automatic check_counters();
        if (hit_count !== exp_hits[15:0])
        begin
            report_mismatch("hit_count", 32'(exp_hits), 32'(hit_count));
        end
        if (miss_count !== exp_misses[15:0])
        begin
            report_mismatch("miss_count", 32'(exp_misses), 32'(miss_count));
        end
    endtask

    task automatic run_request(input stim_t stim);
        logic [`TAG_WIDTH - 1 : 0]      tag;
        logic [`INDEX_WIDTH - 1 : 0]    set;
        logic                           is_read;
        logic                           exp_hit;
        logic [`WORD_WIDTH - 1 : 0]     exp_rdata;
        logic [31:0]                    rnd;
        logic                           got_resp;
        logic                           got_fill;
        logic                           got_wr;
        logic [`ADDR_WIDTH - 1 : 0]     seen_fill_addr;
        cache_pkg::cache_resp_t         seen_resp;
        int                             cycles;

        tag       = stim.addr[`ADDR_WIDTH - 1 -: `TAG_WIDTH];
        set       = stim.addr[`INDEX_WIDTH - 1 : 0];
        is_read   = (stim.op == cache_pkg::op_read);
        exp_hit   = ref_valid[set] && (ref_tag[set] == tag);
        exp_rdata = is_read ? model_mem[stim.addr] : '0;
        if (exp_hit != stim.exp_hit)
        begin
            report_failure("the table's hit flag disagrees with the reference tags");
        end
        take_bits(3, rnd);
        fill_delay     = int'(rnd[2:0]) + 1; // one to eight cycles.
        got_resp       = 1'b0;
        got_fill       = 1'b0;
        got_wr         = 1'b0;
        seen_fill_addr = '0;
        seen_resp      = '0;
        cycles         = 0;
        @(posedge clk_in);
        while (!ready && cycles < RESP_LIMIT)
        begin
            @(posedge clk_in);
            cycles++;
        end
        if (!ready)
        begin
            report_failure("ready never went high, request not issued");
        end
        else
        begin
            req       <= '{stim.op, stim.addr, stim.wdata, stim.mask};
            req_valid <= 1'b1;
            @(posedge clk_in);
            req_valid <= 1'b0;
            cycles = 0;
            while (!got_resp && cycles < RESP_LIMIT)
            begin
                @(posedge clk_in);
                cycles++;
                if (fill_req)
                begin
                    got_fill       = 1'b1;
                    seen_fill_addr = fill_addr;
                end
                if (mem_wr)
                begin
                    got_wr = 1'b1;
                    if (mem_addr !== stim.addr)
                    begin
                        report_mismatch("mem_addr", 32'(stim.addr), 32'(mem_addr));
                    end
                    if (mem_wdata !== stim.wdata)
                    begin
                        report_mismatch("mem_wdata", stim.wdata, mem_wdata);
                    end
                    if (mem_mask !== stim.mask)
                    begin
                        report_mismatch("mem_mask", 32'(stim.mask), 32'(mem_mask));
                    end
                    for (int lane = 0; lane < `BYTE_LANES; lane++)
                    begin
                        if (mem_mask[lane])
                        begin
                            model_mem[mem_addr][lane * 8 +: 8] = mem_wdata[lane * 8 +: 8];
                        end
                    end
                end
                if (resp_valid)
                begin
                    got_resp  = 1'b1;
                    seen_resp = resp;
                end
            end
            if (!got_resp)
            begin
                report_failure("no response from the cache within the time limit");
            end
            else
            begin
                if (seen_resp.hit !== exp_hit)
                begin
                    report_mismatch("resp.hit", 32'(exp_hit), 32'(seen_resp.hit));
                end
                if (seen_resp.rdata !== exp_rdata)
                begin
                    report_mismatch("resp.rdata", exp_rdata, seen_resp.rdata);
                end
            end
            if (is_read && !exp_hit && !got_fill)
            begin
                report_failure("read miss without a fill request");
            end
            else if (is_read && !exp_hit && seen_fill_addr !== stim.addr)
            begin
                report_mismatch("fill_addr", 32'(stim.addr), 32'(seen_fill_addr));
            end
            if ((exp_hit || !is_read) && got_fill)
            begin
                report_failure("fill request raised where none was due");
            end
            if (is_read && got_wr)
            begin
                report_failure("memory write raised on a read");
            end
            if (!is_read && !got_wr)
            begin
                report_failure("write finished without a memory write");
            end
            if (is_read && exp_hit)
            begin
                exp_hits++;
            end
            else if (is_read)
            begin
                exp_misses++;
                ref_valid[set] = 1'b1; // read miss allocates.
                ref_tag[set]   = tag;
            end
            @(posedge clk_in);
            check_counters();
        end
    endtask

    // fill responder, one pulse after a random delay.
    always @(posedge clk_in)
    begin
        fill_valid <= 1'b0;
        if (reset_in)
        begin
            fill_pending = 1'b0;
        end
        else if (fill_pending)
        begin
            if (fill_wait <= 1)
            begin
                fill_valid   <= 1'b1;
                fill_data    <= model_mem[fill_addr_q];
                fill_pending = 1'b0;
            end
            else
            begin
                fill_wait = fill_wait - 1;
            end
        end
        else if (fill_req)
        begin
            fill_pending = 1'b1;
            fill_wait    = fill_delay;
            fill_addr_q  = fill_addr;
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        logic [31:0] word;
        int          errors_before;
        int          failed_tests;
        string       kind;

        reset_in     = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        error_count  = 0;
        failed_tests = 0;
        lfsr_state   = 16'd59;
        for (int a = 0; a < MODEL_WORDS; a++)
        begin
            take_bits(32, word);
            model_mem[a] = word;
        end
        load_tests();
        apply_reset();
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            errors_before = error_count;
            if (tests[t].do_reset)
            begin
                kind = "reset";
                apply_reset();
                @(posedge clk_in);
                check_counters(); // counters cleared by reset.
            end
            else
            begin
                kind = (tests[t].op == cache_pkg::op_read) ? "read" : "write";
                run_request(tests[t]);
            end
            if (error_count == errors_before)
            begin
                $display("test %0d %s 0x%h: pass", t, kind, tests[t].addr);
            end
            else
            begin
                failed_tests++;
                $display("test %0d %s 0x%h: fail, %0d errors", t, kind, tests[t].addr,
                         error_count - errors_before);
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
                 NUM_TESTS - failed_tests, failed_tests, error_count);
        if (error_count == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cache_top.sv */
`default_nettype none
`include "cache_defs.svh"

module cache_top
(
    input  wire                                 clk_in,
    input  wire                                 reset_in,

    input  wire  cache_pkg::cache_req_t         req,
    input  wire                                 req_valid,
    output logic                                ready,
    output cache_pkg::cache_resp_t              resp,
    output logic                                resp_valid,

    output logic                                fill_req,
    output logic [`ADDR_WIDTH - 1 : 0]          fill_addr,
    input  wire                                 fill_valid,
    input  wire  [`WORD_WIDTH - 1 : 0]          fill_data,

    output logic                                mem_wr,
    output logic [`ADDR_WIDTH - 1 : 0]          mem_addr,
    output logic [`WORD_WIDTH - 1 : 0]          mem_wdata,
    output logic [`BYTE_LANES - 1 : 0]          mem_mask,

    output logic [15:0]                         hit_count,
    output logic [15:0]                         miss_count
);

    logic                               hit_evt;
    logic                               miss_evt;
    logic                               tag_we;
    logic [`INDEX_WIDTH - 1 : 0]        tag_waddr;
    logic [`TAG_ENTRY_WIDTH - 1 : 0]    tag_wdata;
    logic [`TAG_ENTRY_WIDTH - 1 : 0]    tag_rdata;
    logic                               tag_valid;
    logic                               data_we;
    logic [`BYTE_LANES - 1 : 0]         data_mask;
    logic [`INDEX_WIDTH - 1 : 0]        data_waddr;
    logic [`WORD_WIDTH - 1 : 0]         data_wdata;
    logic [`WORD_WIDTH - 1 : 0]         data_rdata;
    logic                               rd_en;
    logic [`INDEX_WIDTH - 1 : 0]        rd_addr;

    cache_ctrl_fsm ctrl0
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .req        (req),
        .req_valid  (req_valid),
        .ready      (ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .fill_req   (fill_req),
        .fill_addr  (fill_addr),
        .fill_valid (fill_valid),
        .fill_data  (fill_data),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_mask   (mem_mask),
        .hit_evt    (hit_evt),
        .miss_evt   (miss_evt),
        .tag_we     (tag_we),
        .tag_waddr  (tag_waddr),
        .tag_wdata  (tag_wdata),
        .tag_rdata  (tag_rdata),
        .tag_valid  (tag_valid),
        .data_we    (data_we),
        .data_mask  (data_mask),
        .data_waddr (data_waddr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr)
    );

    // tag array, one byte lane so the strobe doubles as the mask.
    dual_port_lutram
    #(
        .ENTRY_WIDTH (`TAG_ENTRY_WIDTH),
        .NUM_SET     (`NUM_SET),
        .MODE        (cache_pkg::mode_read_first),
        .WITH_VALID  (1'b1)
    )
    tag_ram0
    (
        .clk_in          (clk_in),
        .reset_in        (reset_in),
        .write_access_en (tag_we),
        .write_en        (tag_we),
        .write_set_addr  (tag_waddr),
        .write_data      (tag_wdata),
        .read_access_en  (rd_en),
        .read_set_addr   (rd_addr),
        .read_data       (tag_rdata),
        .read_valid      (tag_valid)
    );

    dual_port_lutram
    #(
        .ENTRY_WIDTH (`WORD_WIDTH),
        .NUM_SET     (`NUM_SET),
        .MODE        (cache_pkg::mode_read_first),
        .WITH_VALID  (1'b0)
    )
    data_ram0
    (
        .clk_in          (clk_in),
        .reset_in        (reset_in),
        .write_access_en (data_we),
        .write_en        (data_mask),
        .write_set_addr  (data_waddr),
        .write_data      (data_wdata),
        .read_access_en  (rd_en),
        .read_set_addr   (rd_addr),
        .read_data       (data_rdata),
        .read_valid      ()
    );

    cache_stat_counters
    #(
        .COUNT_WIDTH (16)
    )
    stats0
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .hit_evt    (hit_evt),
        .miss_evt   (miss_evt),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

endmodule

`default_nettype wire

/* cache/cache_stat_counters.sv */
`default_nettype none

module cache_stat_counters
#(
    parameter int COUNT_WIDTH = 16
)
(
    input  wire                             clk_in,
    input  wire                             reset_in,

    input  wire                             hit_evt,
    input  wire                             miss_evt,

    output logic [COUNT_WIDTH - 1 : 0]      hit_count,
    output logic [COUNT_WIDTH - 1 : 0]      miss_count
);

    function automatic logic [COUNT_WIDTH - 1 : 0] sat_inc(input logic [COUNT_WIDTH - 1 : 0] value);
        return (&value) ? value : value + 1'b1; // hold at all ones.
    endfunction

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            hit_count  <= '0;
            miss_count <= '0;
        end
        else
        begin
            if (hit_evt)
            begin
                hit_count <= sat_inc(hit_count);
            end
            if (miss_evt)
            begin
                miss_count <= sat_inc(miss_count);
            end
        end
    end

    a_evt_exclusive: assert property (@(posedge clk_in) disable iff (reset_in)
        !(hit_evt && miss_evt));

endmodule

`default_nettype wire

/* cache/cache_ctrl_fsm.sv */
`default_nettype none
`include "cache_defs.svh"

module cache_ctrl_fsm
(
    input  wire                                 clk_in,
    input  wire                                 reset_in,

    input  wire  cache_pkg::cache_req_t         req,
    input  wire                                 req_valid,
    output logic                                ready,
    output cache_pkg::cache_resp_t              resp,
    output logic                                resp_valid,

    output logic                                fill_req,
    output logic [`ADDR_WIDTH - 1 : 0]          fill_addr,
    input  wire                                 fill_valid,
    input  wire  [`WORD_WIDTH - 1 : 0]          fill_data,

    output logic                                mem_wr,
    output logic [`ADDR_WIDTH - 1 : 0]          mem_addr,
    output logic [`WORD_WIDTH - 1 : 0]          mem_wdata,
    output logic [`BYTE_LANES - 1 : 0]          mem_mask,

    output logic                                hit_evt,
    output logic                                miss_evt,

    output logic                                tag_we,
    output logic [`INDEX_WIDTH - 1 : 0]         tag_waddr,
    output logic [`TAG_ENTRY_WIDTH - 1 : 0]     tag_wdata,
    input  wire  [`TAG_ENTRY_WIDTH - 1 : 0]     tag_rdata,
    input  wire                                 tag_valid,

    output logic                                data_we,
    output logic [`BYTE_LANES - 1 : 0]          data_mask,
    output logic [`INDEX_WIDTH - 1 : 0]         data_waddr,
    output logic [`WORD_WIDTH - 1 : 0]          data_wdata,
    input  wire  [`WORD_WIDTH - 1 : 0]          data_rdata,

    output logic                                rd_en,
    output logic [`INDEX_WIDTH - 1 : 0]         rd_addr
);

    cache_pkg::ctrl_state_e             state;
    cache_pkg::cache_req_t              req_q;
    logic                               req_take;
    logic                               is_read;
    logic                               lookup_hit;
    logic [`TAG_WIDTH - 1 : 0]          req_tag;
    logic [`INDEX_WIDTH - 1 : 0]        req_index;

    assign req_take  = ready && req_valid;
    assign rd_en     = req_take; // arrays answer in st_lookup.
    assign rd_addr   = req.addr[`INDEX_WIDTH - 1 : 0];

    assign req_tag   = req_q.addr[`ADDR_WIDTH - 1 -: `TAG_WIDTH];
    assign req_index = req_q.addr[`INDEX_WIDTH - 1 : 0];
    assign is_read   = (req_q.op == cache_pkg::op_read);
    assign lookup_hit = tag_valid &&
        (tag_rdata == {{(`TAG_ENTRY_WIDTH - `TAG_WIDTH){1'b0}}, req_tag});

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            state      <= cache_pkg::st_idle;
            ready      <= 1'b0;
            resp_valid <= 1'b0;
            fill_req   <= 1'b0;
            mem_wr     <= 1'b0;
            hit_evt    <= 1'b0;
            miss_evt   <= 1'b0;
            tag_we     <= 1'b0;
            data_we    <= 1'b0;
        end
        else
        begin
            resp_valid <= 1'b0; // all strobes are single cycle.
            fill_req   <= 1'b0;
            mem_wr     <= 1'b0;
            hit_evt    <= 1'b0;
            miss_evt   <= 1'b0;
            tag_we     <= 1'b0;
            data_we    <= 1'b0;
            case (state)
                cache_pkg::st_idle:
                begin
                    ready <= !req_take;
                    if (req_take)
                    begin
                        state <= cache_pkg::st_lookup;
                    end
                end
                cache_pkg::st_lookup:
                begin
                    if (is_read && lookup_hit)
                    begin
                        resp_valid <= 1'b1;
                        hit_evt    <= 1'b1;
                        state      <= cache_pkg::st_respond;
                    end
                    else if (is_read)
                    begin
                        fill_req <= 1'b1;
                        miss_evt <= 1'b1;
                        state    <= cache_pkg::st_fill;
                    end
                    else
                    begin
                        mem_wr     <= 1'b1; // write-through, no allocate.
                        data_we    <= lookup_hit;
                        resp_valid <= 1'b1;
                        state      <= cache_pkg::st_respond;
                    end
                end
                cache_pkg::st_fill:
                begin
                    if (fill_valid)
                    begin
                        tag_we     <= 1'b1;
                        data_we    <= 1'b1;
                        resp_valid <= 1'b1;
                        state      <= cache_pkg::st_respond;
                    end
                end
                default:
                begin
                    ready <= 1'b1;
                    state <= cache_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (req_take)
        begin
            req_q <= req;
        end
        if (state == cache_pkg::st_lookup)
        begin
            resp.rdata <= is_read ? data_rdata : '0;
            resp.hit   <= lookup_hit;
            fill_addr  <= req_q.addr;
            mem_addr   <= req_q.addr;
            mem_wdata  <= req_q.wdata;
            mem_mask   <= req_q.mask;
            data_mask  <= req_q.mask;
            data_waddr <= req_index;
            data_wdata <= req_q.wdata;
        end
        else if ((state == cache_pkg::st_fill) && fill_valid)
        begin
            resp.rdata <= fill_data;
            resp.hit   <= 1'b0;
            tag_waddr  <= req_index;
            tag_wdata  <= {{(`TAG_ENTRY_WIDTH - `TAG_WIDTH){1'b0}}, req_tag};
            data_mask  <= '1; // whole word on a fill.
            data_waddr <= req_index;
            data_wdata <= fill_data;
        end
    end

    a_fill_in_fill_state: assert property (@(posedge clk_in) disable iff (reset_in)
        fill_valid |-> (state == cache_pkg::st_fill));

    a_resp_single_cycle: assert property (@(posedge clk_in) disable iff (reset_in)
        resp_valid |=> !resp_valid);

endmodule

`default_nettype wire

/* hw/dual_port_lutram.sv */
`default_nettype none
`include "cache_defs.svh"

module dual_port_lutram
#(
    parameter int                      ENTRY_WIDTH = `WORD_WIDTH,
    parameter int                      NUM_SET     = `NUM_SET,
    parameter cache_pkg::lutram_mode_e MODE        = cache_pkg::mode_read_first,
    parameter bit                      WITH_VALID  = 1'b1
)
(
    input  wire                                                  clk_in,
    input  wire                                                  reset_in,

    input  wire                                                  write_access_en,
    input  wire  [ENTRY_WIDTH / `BYTE_LEN_IN_BITS - 1 : 0]       write_en,
    input  wire  [$clog2(NUM_SET) - 1 : 0]                       write_set_addr,
    input  wire  [ENTRY_WIDTH - 1 : 0]                           write_data,

    input  wire                                                  read_access_en,
    input  wire  [$clog2(NUM_SET) - 1 : 0]                       read_set_addr,
    output logic [ENTRY_WIDTH - 1 : 0]                           read_data,
    output logic                                                 read_valid
);

    localparam int MASK_LEN = ENTRY_WIDTH / `BYTE_LEN_IN_BITS;

    logic [ENTRY_WIDTH - 1 : 0] mem [NUM_SET];
    logic [ENTRY_WIDTH - 1 : 0] full_mask;
    logic                       fwd_en;

    genvar bit_idx;
    for (bit_idx = 0; bit_idx < ENTRY_WIDTH; bit_idx = bit_idx + 1)
    begin : g_full_mask
        assign full_mask[bit_idx] = write_en[bit_idx / `BYTE_LEN_IN_BITS];
    end

    // same-set write seen by the read in write-first mode only.
    assign fwd_en = (MODE == cache_pkg::mode_write_first) && read_access_en &&
                    write_access_en && (|write_en) && (read_set_addr == write_set_addr);

    always_ff @(posedge clk_in)
    begin
        if (write_access_en)
        begin
            for (int lane = 0; lane < MASK_LEN; lane++)
            begin
                if (write_en[lane])
                begin
                    mem[write_set_addr][lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS] <=
                        write_data[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
                end
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (fwd_en)
        begin
            read_data <= (write_data & full_mask) | (mem[read_set_addr] & ~full_mask);
        end
        else if (read_access_en)
        begin
            read_data <= mem[read_set_addr]; // old contents on a collision.
        end
    end

    if (WITH_VALID)
    begin : g_valid
        logic [NUM_SET - 1 : 0] valid_array;

        always_ff @(posedge clk_in)
        begin
            if (reset_in)
            begin
                valid_array <= '0;
                read_valid  <= 1'b0;
            end
            else
            begin
                if (write_access_en && (|write_en))
                begin
                    valid_array[write_set_addr] <= 1'b1;
                end
                read_valid <= read_access_en && (valid_array[read_set_addr] || fwd_en);
            end
        end
    end
    else
    begin : g_no_valid
        always_ff @(posedge clk_in)
        begin
            if (reset_in)
            begin
                read_valid <= 1'b0;
            end
            else
            begin
                read_valid <= read_access_en; // every set counts as valid.
            end
        end
    end

    a_read_addr_known: assert property (@(posedge clk_in) disable iff (reset_in)
        read_access_en |-> !$isunknown(read_set_addr));

endmodule

`default_nettype wire

/* common/cache_pkg.sv */
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

    typedef enum logic
    {
        op_read,
        op_write
    } cache_op_e;

    typedef struct packed
    {
        cache_op_e                    op;
        logic [`ADDR_WIDTH - 1 : 0]   addr;
        logic [`WORD_WIDTH - 1 : 0]   wdata;
        logic [`BYTE_LANES - 1 : 0]   mask;
    } cache_req_t;

    typedef struct packed
    {
        logic [`WORD_WIDTH - 1 : 0]   rdata; // zero for writes.
        logic                         hit;
    } cache_resp_t;

    typedef enum logic [1:0]
    {
        st_idle,
        st_lookup,
        st_fill,
        st_respond
    } ctrl_state_e;

    typedef enum logic
    {
        mode_read_first,
        mode_write_first
    } lutram_mode_e;

endpackage

`default_nettype wire

/* common/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// word and byte lane geometry.
`define BYTE_LEN_IN_BITS 8
`define WORD_WIDTH       32
`define BYTE_LANES       4

// set geometry, 16 sets of one word each.
`define NUM_SET          16
`define INDEX_WIDTH      4

// word address split into tag and index.
`define ADDR_WIDTH       8
`define TAG_WIDTH        4

// tag entry occupies one byte lane.
`define TAG_ENTRY_WIDTH  8

`endif
